// File: hw/dmaRegPkg.sv
package dmaRegPkg;

  // address and count registers are a full 16-bit word
  localparam int addrWidth = 16;

  // cpu side is a byte port
  localparam int dataWidth = 8;

  // register select driven by the cpu
  localparam int regSelWidth = 4;

  // register map seen from the cpu port
  // channel n address sits at 2n, its count at 2n+1
  typedef enum logic [regSelWidth-1:0] {
    selAddr0       = 4'd0,
    selCount0      = 4'd1,
    selAddr1       = 4'd2,
    selCount1      = 4'd3,
    selAddr2       = 4'd4,
    selCount2      = 4'd5,
    selAddr3       = 4'd6,
    selCount3      = 4'd7,
    selCmdStatus   = 4'd8,
    selSingleMask  = 4'd10,
    selMode        = 4'd11,
    selClearPtr    = 4'd12,
    selMasterClear = 4'd13
  } dmaRegSel;

  // command register bits
  localparam int cmdDisableBit = 2;
  localparam int cmdRotateBit = 4;

  // mode register, transfer type field starts here
  localparam int modeTypeLsb = 2;

  // single mask write, set or clear flag
  localparam int maskSetBit = 2;

endpackage

// File: hw/dmaCtrlPkg.sv
package dmaCtrlPkg;

  // four peer channels share the bus
  localparam int numChannels = 4;
  localparam int chanWidth = 2;

  // bus cycle states
  // s3 is never used, the cycle runs s1 s2 s4
  typedef enum logic [2:0] {
    stIdle,
    stHold,
    stS1,
    stS2,
    stS4
  } dmaState;

  // 2-bit transfer type field of the mode register
  // 11 is reserved and behaves like verify
  typedef enum logic [1:0] {
    xferVerify = 2'b00,
    xferWrite  = 2'b01,
    xferRead   = 2'b10
  } dmaTransferType;

endpackage

// File: hw/dmaRegisterFile.sv
`timescale 1ns/1ns

module dmaRegisterFile (
  input  logic                                 busIf,
  input  logic                                 rstN,
  input  logic                                 csN,
  input  logic                                 regWr,
  input  logic                                 regRd,
  input  logic [dmaRegPkg::regSelWidth-1:0]    regSel,
  input  logic [dmaRegPkg::dataWidth-1:0]      regWrData,
  output logic [dmaRegPkg::dataWidth-1:0]      regRdData,
  input  logic [dmaCtrlPkg::numChannels-1:0]   dreq,
  input  logic [dmaCtrlPkg::chanWidth-1:0]     grantChan,
  input  logic                                 xferDone,
  output logic [dmaCtrlPkg::numChannels-1:0]   chanMask,
  output logic                                 cmdDisable,
  output logic                                 cmdRotate,
  output dmaCtrlPkg::dmaTransferType           grantType,
  output logic [dmaRegPkg::addrWidth-1:0]      grantAddr,
  output logic                                 lastWord
);

  // per channel word registers
  logic [dmaRegPkg::addrWidth-1:0] baseAddr [dmaCtrlPkg::numChannels];
  logic [dmaRegPkg::addrWidth-1:0] curAddr [dmaCtrlPkg::numChannels];
  logic [dmaRegPkg::addrWidth-1:0] baseCount [dmaCtrlPkg::numChannels];
  logic [dmaRegPkg::addrWidth-1:0] curCount [dmaCtrlPkg::numChannels];
  dmaCtrlPkg::dmaTransferType modeType [dmaCtrlPkg::numChannels];

  // terminal count flags, low nibble of status
  logic [dmaCtrlPkg::numChannels-1:0] tcStatus;
  // low byte first, flips on every word register access
  logic bytePtr;

  logic wrEn;
  logic rdEn;
  logic chanRegSel;
  logic selIsCount;
  logic [dmaCtrlPkg::chanWidth-1:0] selChan;
  logic [dmaRegPkg::addrWidth-1:0] regVal;

  // cpu strobes qualified by chip select
  assign wrEn = !csN && regWr;
  assign rdEn = !csN && regRd;

  // selects 0..7 address the channel words
  assign chanRegSel = (regSel < dmaRegPkg::selCmdStatus);
  assign selChan = regSel[dmaCtrlPkg::chanWidth:1];
  assign selIsCount = regSel[0];

  // word registers, loaded from the cpu and stepped by transfers
  always_ff @(posedge busIf) begin
    if (wrEn && chanRegSel) begin
      if (selIsCount) begin
        if (!bytePtr) begin
          baseCount[selChan][dmaRegPkg::dataWidth-1:0] <= regWrData;
        end else begin
          baseCount[selChan][dmaRegPkg::addrWidth-1:dmaRegPkg::dataWidth] <= regWrData;
          // current count takes the whole word once the high byte lands
          curCount[selChan] <= {regWrData, baseCount[selChan][dmaRegPkg::dataWidth-1:0]};
        end
      end else begin
        if (!bytePtr) begin
          baseAddr[selChan][dmaRegPkg::dataWidth-1:0] <= regWrData;
        end else begin
          baseAddr[selChan][dmaRegPkg::addrWidth-1:dmaRegPkg::dataWidth] <= regWrData;
          curAddr[selChan] <= {regWrData, baseAddr[selChan][dmaRegPkg::dataWidth-1:0]};
        end
      end
    end
    // one transfer finished, step the granted channel
    if (xferDone) begin
      curAddr[grantChan] <= curAddr[grantChan] + 1'b1;
      curCount[grantChan] <= curCount[grantChan] - 1'b1;
    end
  end

  // command, mode, mask, status and byte pointer
  always_ff @(posedge busIf) begin
    if (!rstN) begin
      cmdDisable <= 1'b0;
      cmdRotate <= 1'b0;
      chanMask <= '1;
      tcStatus <= '0;
      bytePtr <= 1'b0;
      for (int i = 0; i < dmaCtrlPkg::numChannels; i++) begin
        modeType[i] <= dmaCtrlPkg::xferVerify;
      end
    end else begin
      if (wrEn) begin
        case (regSel)
          dmaRegPkg::selCmdStatus: begin
            cmdDisable <= regWrData[dmaRegPkg::cmdDisableBit];
            cmdRotate <= regWrData[dmaRegPkg::cmdRotateBit];
          end
          // low bits pick the channel, bit 2 sets or clears its mask
          dmaRegPkg::selSingleMask:
            chanMask[regWrData[dmaCtrlPkg::chanWidth-1:0]] <= regWrData[dmaRegPkg::maskSetBit];
          dmaRegPkg::selMode:
            modeType[regWrData[dmaCtrlPkg::chanWidth-1:0]] <= dmaCtrlPkg::dmaTransferType'(
              regWrData[dmaRegPkg::modeTypeLsb +: $bits(dmaCtrlPkg::dmaTransferType)]);
          default: ;
        endcase
      end
      // any word access moves the pointer to the other byte
      if ((wrEn || rdEn) && chanRegSel) begin
        bytePtr <= !bytePtr;
      end
      if (wrEn && regSel == dmaRegPkg::selClearPtr) begin
        bytePtr <= 1'b0;
      end
      // status read is destructive
      if (rdEn && regSel == dmaRegPkg::selCmdStatus) begin
        tcStatus <= '0;
      end
      // last transfer flags the channel and masks it off
      if (xferDone && lastWord) begin
        tcStatus[grantChan] <= 1'b1;
        chanMask[grantChan] <= 1'b1;
      end
      if (wrEn && regSel == dmaRegPkg::selMasterClear) begin
        cmdDisable <= 1'b0;
        cmdRotate <= 1'b0;
        chanMask <= '1;
        tcStatus <= '0;
        bytePtr <= 1'b0;
      end
    end
  end

  // cpu read path, combinational while the read strobe is up
  always_comb begin
    regVal = selIsCount ? curCount[selChan] : curAddr[selChan];
    regRdData = '0;
    if (rdEn) begin
      if (chanRegSel) begin
        regRdData = bytePtr ? regVal[dmaRegPkg::addrWidth-1:dmaRegPkg::dataWidth]
                            : regVal[dmaRegPkg::dataWidth-1:0];
      end else if (regSel == dmaRegPkg::selCmdStatus) begin
        // pending requests on top, terminal counts below
        regRdData = {dreq, tcStatus};
      end
    end
  end

  // view of the granted channel for the bus cycle
  assign grantType = modeType[grantChan];
  assign grantAddr = curAddr[grantChan];
  assign lastWord = (curCount[grantChan] == '0);

endmodule

// File: hw/dmaPriorityArbiter.sv
`timescale 1ns/1ns

module dmaPriorityArbiter (
  input  logic                               busIf,
  input  logic                               rstN,
  input  logic [dmaCtrlPkg::numChannels-1:0] dreq,
  input  logic [dmaCtrlPkg::numChannels-1:0] chanMask,
  input  logic                               cmdDisable,
  input  logic                               cmdRotate,
  input  logic                               grantTake,
  input  logic                               xferDone,
  output logic                               reqValid,
  output logic [dmaCtrlPkg::chanWidth-1:0]   grantChan
);

  logic [dmaCtrlPkg::numChannels-1:0] eligible;
  // channel served last, lowest priority in rotating mode
  logic [dmaCtrlPkg::chanWidth-1:0] lastServed;
  logic [dmaCtrlPkg::chanWidth-1:0] startChan;
  logic [dmaCtrlPkg::chanWidth-1:0] probe;
  logic [dmaCtrlPkg::chanWidth-1:0] pickChan;
  logic found;

  // unmasked requests, nothing while the controller is disabled
  assign eligible = dreq & ~chanMask & {dmaCtrlPkg::numChannels{!cmdDisable}};
  assign reqValid = |eligible;

  // fixed mode searches from channel 0
  // rotating mode starts just after the last one served
  assign startChan = cmdRotate ? lastServed + 1'b1 : '0;

  always_comb begin
    pickChan = '0;
    probe = '0;
    found = 1'b0;
    for (int i = 0; i < dmaCtrlPkg::numChannels; i++) begin
      probe = startChan + i[dmaCtrlPkg::chanWidth-1:0];
      // first hit in search order wins
      if (!found && eligible[probe]) begin
        pickChan = probe;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge busIf) begin
    if (!rstN) begin
      grantChan <= '0;
      // channel 3 lowest, so channel 0 leads after reset
      lastServed <= '1;
    end else begin
      // grant frozen for the whole bus cycle
      if (grantTake) begin
        grantChan <= pickChan;
      end
      if (xferDone && cmdRotate) begin
        lastServed <= grantChan;
      end
    end
  end

endmodule

// File: hw/dmaTimingControl.sv
`timescale 1ns/1ns

module dmaTimingControl (
  input  logic                               busIf,
  input  logic                               rstN,
  input  logic                               reqValid,
  input  logic                               hlda,
  input  logic [dmaCtrlPkg::chanWidth-1:0]   grantChan,
  input  dmaCtrlPkg::dmaTransferType         grantType,
  input  logic [dmaRegPkg::addrWidth-1:0]    grantAddr,
  input  logic                               lastWord,
  output logic                               grantTake,
  output logic                               xferDone,
  output logic                               hrq,
  output logic                               aen,
  output logic                               adstb,
  output logic [dmaRegPkg::addrWidth-1:0]    addr,
  output logic [dmaCtrlPkg::numChannels-1:0] dack,
  output logic                               memrN,
  output logic                               memwN,
  output logic                               iorN,
  output logic                               iowN,
  output logic                               tc
);

  dmaCtrlPkg::dmaState state;
  dmaCtrlPkg::dmaState nextState;

  // strobe windows within the bus cycle
  logic readPhase;
  logic writePhase;
  logic isRead;
  logic isWrite;

  always_ff @(posedge busIf) begin
    if (!rstN) begin
      state <= dmaCtrlPkg::stIdle;
    end else begin
      state <= nextState;
    end
  end

  // idle -> hold -> s1 -> s2 -> s4 -> idle
  always_comb begin
    nextState = state;
    case (state)
      dmaCtrlPkg::stIdle: begin
        if (reqValid) begin
          nextState = dmaCtrlPkg::stHold;
        end
      end
      // wait here as long as the cpu keeps the bus
      dmaCtrlPkg::stHold: begin
        if (hlda) begin
          nextState = dmaCtrlPkg::stS1;
        end
      end
      dmaCtrlPkg::stS1: nextState = dmaCtrlPkg::stS2;
      // s3 skipped, no wait states
      dmaCtrlPkg::stS2: nextState = dmaCtrlPkg::stS4;
      dmaCtrlPkg::stS4: nextState = dmaCtrlPkg::stIdle;
      default: nextState = dmaCtrlPkg::stIdle;
    endcase
  end

  // arbiter latches its pick as we leave idle
  assign grantTake = (state == dmaCtrlPkg::stIdle) && reqValid;
  // one pulse per transfer, in s4
  assign xferDone = (state == dmaCtrlPkg::stS4);
  assign tc = xferDone && lastWord;

  // hold request from hold through s4
  assign hrq = (state != dmaCtrlPkg::stIdle);

  // controller owns the address bus in s1, s2, s4
  assign aen = (state == dmaCtrlPkg::stS1) || (state == dmaCtrlPkg::stS2) ||
               (state == dmaCtrlPkg::stS4);
  assign adstb = (state == dmaCtrlPkg::stS1);
  assign addr = aen ? grantAddr : '0;

  // one-hot acknowledge for the granted channel
  always_comb begin
    dack = '0;
    for (int i = 0; i < dmaCtrlPkg::numChannels; i++) begin
      dack[i] = aen && (grantChan == i[dmaCtrlPkg::chanWidth-1:0]);
    end
  end

  // read strobe opens in s2, write strobe only in s4
  assign readPhase = (state == dmaCtrlPkg::stS2) || (state == dmaCtrlPkg::stS4);
  assign writePhase = (state == dmaCtrlPkg::stS4);

  // read type moves memory to io, write type io to memory
  assign isRead = (grantType == dmaCtrlPkg::xferRead);
  assign isWrite = (grantType == dmaCtrlPkg::xferWrite);

  // active low strobes, verify leaves all of them high
  assign memrN = !(readPhase && isRead);
  assign iowN = !(writePhase && isRead);
  assign iorN = !(readPhase && isWrite);
  assign memwN = !(writePhase && isWrite);

endmodule

// File: hw/dmaTop.sv
`timescale 1ns/1ns

module dmaTop (
  input  logic                               busIf,
  input  logic                               rstN,
  // cpu register port
  input  logic                               csN,
  input  logic                               regWr,
  input  logic                               regRd,
  input  logic [dmaRegPkg::regSelWidth-1:0]  regSel,
  input  logic [dmaRegPkg::dataWidth-1:0]    regWrData,
  output logic [dmaRegPkg::dataWidth-1:0]    regRdData,
  // system bus
  input  logic [dmaCtrlPkg::numChannels-1:0] dreq,
  input  logic                               hlda,
  output logic                               hrq,
  output logic [dmaCtrlPkg::numChannels-1:0] dack,
  output logic                               aen,
  output logic                               adstb,
  output logic [dmaRegPkg::addrWidth-1:0]    addr,
  output logic                               memrN,
  output logic                               memwN,
  output logic                               iorN,
  output logic                               iowN,
  output logic                               tc
);

  // register file to arbiter
  logic [dmaCtrlPkg::numChannels-1:0] chanMask;
  logic cmdDisable;
  logic cmdRotate;

  // register file to timing control
  dmaCtrlPkg::dmaTransferType grantType;
  logic [dmaRegPkg::addrWidth-1:0] grantAddr;
  logic lastWord;

  // arbiter and timing control handshake
  logic reqValid;
  logic [dmaCtrlPkg::chanWidth-1:0] grantChan;
  logic grantTake;
  logic xferDone;

  dmaRegisterFile regFile (
    .busIf(busIf), .rstN(rstN), .csN(csN), .regWr(regWr), .regRd(regRd),
    .regSel(regSel), .regWrData(regWrData), .regRdData(regRdData), .dreq(dreq),
    .grantChan(grantChan), .xferDone(xferDone), .chanMask(chanMask),
    .cmdDisable(cmdDisable), .cmdRotate(cmdRotate), .grantType(grantType),
    .grantAddr(grantAddr), .lastWord(lastWord)
  );

  dmaPriorityArbiter priorityArb (
    .busIf(busIf), .rstN(rstN), .dreq(dreq), .chanMask(chanMask),
    .cmdDisable(cmdDisable), .cmdRotate(cmdRotate), .grantTake(grantTake),
    .xferDone(xferDone), .reqValid(reqValid), .grantChan(grantChan)
  );

  dmaTimingControl timingCtrl (
    .busIf(busIf), .rstN(rstN), .reqValid(reqValid), .hlda(hlda),
    .grantChan(grantChan), .grantType(grantType), .grantAddr(grantAddr),
    .lastWord(lastWord), .grantTake(grantTake), .xferDone(xferDone), .hrq(hrq),
    .aen(aen), .adstb(adstb), .addr(addr), .dack(dack), .memrN(memrN),
    .memwN(memwN), .iorN(iorN), .iowN(iowN), .tc(tc)
  );

endmodule

// File: tests/dmaClockGen.sv
`timescale 1ns/1ns

module dmaClockGen (
  output logic busIf
);

  // 100 ns bus clock
  localparam int halfPeriod = 50;

  initial begin
    busIf = 1'b0;
    forever #halfPeriod busIf = !busIf;
  end

endmodule

// File: tests/dmaTiming_checker.sv
`timescale 1ns/1ns

module dmaTiming_checker (
  input logic                               busIf,
  input logic                               rstN,
  input dmaCtrlPkg::dmaState                state,
  input logic                               hlda,
  input logic                               aen,
  input logic                               adstb,
  input logic [dmaCtrlPkg::numChannels-1:0] dack,
  input logic                               memrN,
  input logic                               memwN
);

  // one failure counter per property
  int holdErrs = 0;
  int s1Errs = 0;
  int s2Errs = 0;
  int s4Errs = 0;
  int dackErrs = 0;
  int strobeErrs = 0;
  int adstbErrs = 0;
  int violationCount;

  assign violationCount = holdErrs + s1Errs + s2Errs + s4Errs + dackErrs + strobeErrs +
                          adstbErrs;

  // cpu has released the bus, cycle starts
  holdToS1: assert property (@(posedge busIf) disable iff (!rstN)
    (state == dmaCtrlPkg::stHold && hlda) |=> state == dmaCtrlPkg::stS1)
    else begin
      $error("state stayed out of s1 after hlda in hold");
      holdErrs++;
    end

  // fixed s1 s2 s4 sequence, s3 never entered
  s1ToS2: assert property (@(posedge busIf) disable iff (!rstN)
    state == dmaCtrlPkg::stS1 |=> state == dmaCtrlPkg::stS2)
    else begin
      $error("s1 not followed by s2");
      s1Errs++;
    end

  s2ToS4: assert property (@(posedge busIf) disable iff (!rstN)
    state == dmaCtrlPkg::stS2 |=> state == dmaCtrlPkg::stS4)
    else begin
      $error("s2 not followed by s4");
      s2Errs++;
    end

  s4ToIdle: assert property (@(posedge busIf) disable iff (!rstN)
    state == dmaCtrlPkg::stS4 |=> state == dmaCtrlPkg::stIdle)
    else begin
      $error("s4 not followed by idle");
      s4Errs++;
    end

  // at most one channel acknowledged
  dackOneHot: assert property (@(posedge busIf) disable iff (!rstN) $onehot0(dack))
    else begin
      $error("dack has more than one bit set");
      dackErrs++;
    end

  // memory read and write never overlap
  memStrobes: assert property (@(posedge busIf) disable iff (!rstN) !(!memrN && !memwN))
    else begin
      $error("memrN and memwN low together");
      strobeErrs++;
    end

  // address strobe only while the controller owns the bus
  adstbInAen: assert property (@(posedge busIf) disable iff (!rstN) adstb |-> aen)
    else begin
      $error("adstb active without aen");
      adstbErrs++;
    end

endmodule

// File: tests/dmaTb.sv
`timescale 1ns/1ns

module dmaTb;

  localparam int resetCycles = 16;
  // read data sampled a quarter period after the falling edge
  localparam int sampleDelay = 25;
  // longest wait from request to s1
  localparam int cycleWaitLimit = 12;
  // worst case length of each test in cycles
  localparam int resetTestCycles = 40;
  localparam int regTestCycles = 60;
  localparam int singleTestCycles = 60;
  localparam int tcTestCycles = 80;
  localparam int fixedTestCycles = 120;
  localparam int rotateTestCycles = 140;
  localparam int cycleLimit = 2 * (resetCycles + resetTestCycles + regTestCycles +
                                   singleTestCycles + tcTestCycles + fixedTestCycles +
                                   rotateTestCycles);

  logic busIf;
  logic rstN;
  logic csN;
  logic regWr;
  logic regRd;
  logic [dmaRegPkg::regSelWidth-1:0] regSel;
  logic [dmaRegPkg::dataWidth-1:0] regWrData;
  logic [dmaRegPkg::dataWidth-1:0] regRdData;
  logic [dmaCtrlPkg::numChannels-1:0] dreq;
  logic hlda = 1'b0;
  logic hrq;
  logic [dmaCtrlPkg::numChannels-1:0] dack;
  logic aen;
  logic adstb;
  logic [dmaRegPkg::addrWidth-1:0] addr;
  logic memrN;
  logic memwN;
  logic iorN;
  logic iowN;
  logic tc;

  // bus responder state
  logic hrqSeen = 1'b0;

  integer seed;
  int cycleCount = 0;
  int errorCount = 0;
  int checkCount = 0;
  int testsRun = 0;
  int testsFailed = 0;

  // expected channel registers, stepped per observed transfer
  logic [dmaRegPkg::addrWidth-1:0] modelAddr [dmaCtrlPkg::numChannels];
  logic [dmaRegPkg::addrWidth-1:0] modelCount [dmaCtrlPkg::numChannels];
  dmaCtrlPkg::dmaTransferType modelType [dmaCtrlPkg::numChannels];
  logic [dmaCtrlPkg::numChannels-1:0] modelStatus = '0;

  dmaClockGen clockGen (
    .busIf(busIf)
  );

  dmaTop dmaTop_inst (
    .busIf(busIf), .rstN(rstN), .csN(csN), .regWr(regWr), .regRd(regRd),
    .regSel(regSel), .regWrData(regWrData), .regRdData(regRdData), .dreq(dreq),
    .hlda(hlda), .hrq(hrq), .dack(dack), .aen(aen), .adstb(adstb), .addr(addr),
    .memrN(memrN), .memwN(memwN), .iorN(iorN), .iowN(iowN), .tc(tc)
  );

  bind dmaTimingControl dmaTiming_checker timingChecker (
    .busIf(busIf), .rstN(rstN), .state(state), .hlda(hlda), .aen(aen),
    .adstb(adstb), .dack(dack), .memrN(memrN), .memwN(memwN)
  );

  // cpu grants the bus one cycle after it sees hrq
  always @(negedge busIf) begin
    if (!rstN) begin
      hrqSeen <= 1'b0;
      hlda <= 1'b0;
    end else begin
      hlda <= hrqSeen;
      hrqSeen <= hrq;
    end
  end

  // testbench errors plus bound assertion failures
  function automatic int currentErrors();
    return errorCount + dmaTop_inst.timingCtrl.timingChecker.violationCount;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  task automatic cpuWrite(input logic [3:0] sel, input logic [7:0] data);
    @(negedge busIf);
    csN = 1'b0;
    regWr = 1'b1;
    regSel = sel;
    regWrData = data;
    @(negedge busIf);
    csN = 1'b1;
    regWr = 1'b0;
  endtask

  task automatic cpuRead(input logic [3:0] sel, output logic [7:0] data);
    @(negedge busIf);
    csN = 1'b0;
    regRd = 1'b1;
    regSel = sel;
    #sampleDelay;
    data = regRdData;
    @(negedge busIf);
    csN = 1'b1;
    regRd = 1'b0;
  endtask

  // 16-bit access, low byte first from a cleared pointer
  task automatic writeWord(input logic [3:0] sel, input logic [15:0] word);
    cpuWrite(dmaRegPkg::selClearPtr, 8'h00);
    cpuWrite(sel, word[7:0]);
    cpuWrite(sel, word[15:8]);
  endtask

  task automatic readWord(input logic [3:0] sel, output logic [15:0] word);
    logic [7:0] lo;
    logic [7:0] hi;
    cpuWrite(dmaRegPkg::selClearPtr, 8'h00);
    cpuRead(sel, lo);
    cpuRead(sel, hi);
    word = {hi, lo};
  endtask

  // masked while loading, unmasked at the end
  task automatic programChannel(input int chan, input logic [15:0] base,
                                input logic [15:0] count,
                                input dmaCtrlPkg::dmaTransferType xtype);
    cpuWrite(dmaRegPkg::selSingleMask, 8'((1 << dmaRegPkg::maskSetBit) | chan));
    writeWord(4'(2 * chan), base);
    writeWord(4'(2 * chan + 1), count);
    cpuWrite(dmaRegPkg::selMode, 8'((int'(xtype) << dmaRegPkg::modeTypeLsb) | chan));
    cpuWrite(dmaRegPkg::selSingleMask, 8'(chan));
    modelAddr[chan] = base;
    modelCount[chan] = count;
    modelType[chan] = xtype;
  endtask

  // phase 0, 1, 2 are s1, s2, s4
  task automatic checkPhase(input int chan, input int phase);
    bit readOn;
    bit writeOn;
    bit isRead;
    bit isWrite;
    bit expTc;
    readOn = (phase != 0);
    writeOn = (phase == 2);
    isRead = (modelType[chan] == dmaCtrlPkg::xferRead);
    isWrite = (modelType[chan] == dmaCtrlPkg::xferWrite);
    // tc only in s4 of the transfer made at count zero
    expTc = writeOn && (modelCount[chan] == '0);
    compareValue("hrq", 32'(hrq), 1);
    compareValue("aen", 32'(aen), 1);
    compareValue("adstb", 32'(adstb), 32'(phase == 0));
    compareValue("dack", 32'(dack), 1 << chan);
    compareValue("addr", 32'(addr), 32'(modelAddr[chan]));
    compareValue("memrN", 32'(memrN), 32'(!(readOn && isRead)));
    compareValue("iowN", 32'(iowN), 32'(!(writeOn && isRead)));
    compareValue("iorN", 32'(iorN), 32'(!(readOn && isWrite)));
    compareValue("memwN", 32'(memwN), 32'(!(writeOn && isWrite)));
    compareValue("tc", 32'(tc), 32'(expTc));
  endtask

  // waits for s1, checks the three bus cycle states, steps the model
  task automatic observeCycle(input int chan);
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < cycleWaitLimit) begin
      @(negedge busIf);
      if (aen) begin
        seen = 1'b1;
      end else begin
        waited++;
      end
    end
    checkCount++;
    assert (seen) else begin
      $display("error at %0t ns: no bus cycle for channel %0d within %0d cycles",
               $time, chan, cycleWaitLimit);
      errorCount++;
    end
    if (seen) begin
      checkPhase(chan, 0);
      @(negedge busIf);
      checkPhase(chan, 1);
      @(negedge busIf);
      checkPhase(chan, 2);
      if (modelCount[chan] == '0) begin
        modelStatus[chan] = 1'b1;
      end
      modelAddr[chan] = modelAddr[chan] + 16'd1;
      modelCount[chan] = modelCount[chan] - 16'd1;
    end
  endtask

  task automatic expectBusIdle(input int cycles);
    repeat (cycles) begin
      @(negedge busIf);
      compareValue("hrq", 32'(hrq), 0);
      compareValue("dack", 32'(dack), 0);
    end
  endtask

  task automatic finishTest(input int num, input string name, input int startErrors);
    int newErrors;
    newErrors = currentErrors() - startErrors;
    testsRun++;
    if (newErrors == 0) begin
      $display("test %0d, %s: ok", num, name);
    end else begin
      $display("test %0d, %s: failed with %0d errors", num, name, newErrors);
      testsFailed++;
    end
  endtask

  task automatic resetStateTest();
    int startErrors;
    startErrors = currentErrors();
    @(negedge busIf);
    compareValue("hrq", 32'(hrq), 0);
    compareValue("aen", 32'(aen), 0);
    compareValue("adstb", 32'(adstb), 0);
    compareValue("tc", 32'(tc), 0);
    compareValue("dack", 32'(dack), 0);
    compareValue("strobes", 32'({memrN, memwN, iorN, iowN}), 32'hf);
    // every channel masked out of reset
    dreq = 4'b1111;
    expectBusIdle(8);
    dreq = 4'b0000;
    finishTest(1, "reset state", startErrors);
  endtask

  task automatic registerReadbackTest();
    int startErrors;
    logic [15:0] base;
    logic [15:0] word;
    startErrors = currentErrors();
    base = 16'($random(seed));
    programChannel(2, base, 16'h0010, dmaCtrlPkg::xferVerify);
    readWord(dmaRegPkg::selAddr2, word);
    compareValue("channel 2 address", 32'(word), 32'(base));
    readWord(dmaRegPkg::selCount2, word);
    compareValue("channel 2 count", 32'(word), 32'h0010);
    // master clear puts the mask back on
    cpuWrite(dmaRegPkg::selMasterClear, 8'h00);
    modelStatus = '0;
    dreq = 4'b0100;
    expectBusIdle(8);
    dreq = 4'b0000;
    finishTest(2, "register read-back", startErrors);
  endtask

  task automatic singleTransferTest();
    int startErrors;
    logic [15:0] word;
    startErrors = currentErrors();
    programChannel(1, 16'($random(seed)), 16'h0004, dmaCtrlPkg::xferRead);
    dreq = 4'b0010;
    observeCycle(1);
    dreq = 4'b0000;
    expectBusIdle(2);
    // address and count stepped on leaving s4
    readWord(dmaRegPkg::selAddr1, word);
    compareValue("channel 1 address", 32'(word), 32'(modelAddr[1]));
    readWord(dmaRegPkg::selCount1, word);
    compareValue("channel 1 count", 32'(word), 32'(modelCount[1]));
    finishTest(3, "single read transfer", startErrors);
  endtask

  task automatic terminalCountTest();
    int startErrors;
    logic [7:0] status;
    startErrors = currentErrors();
    // count 2 gives three transfers
    programChannel(3, 16'($random(seed)), 16'd2, dmaCtrlPkg::xferRead);
    dreq = 4'b1000;
    for (int i = 0; i < 3; i++) begin
      observeCycle(3);
    end
    // channel masks itself, held request is ignored
    expectBusIdle(10);
    cpuRead(dmaRegPkg::selCmdStatus, status);
    compareValue("status", 32'(status), 32'({dreq, modelStatus}));
    modelStatus = '0;
    dreq = 4'b0000;
    cpuRead(dmaRegPkg::selCmdStatus, status);
    compareValue("status after read", 32'(status), 32'({dreq, modelStatus}));
    finishTest(4, "terminal count", startErrors);
  endtask

  task automatic fixedPriorityTest();
    int startErrors;
    startErrors = currentErrors();
    cpuWrite(dmaRegPkg::selCmdStatus, 8'h00);
    for (int ch = 0; ch < dmaCtrlPkg::numChannels; ch++) begin
      programChannel(ch, 16'($random(seed)), 16'd8, dmaCtrlPkg::xferRead);
    end
    // lowest numbered requester wins
    dreq = 4'b1110;
    observeCycle(1);
    dreq = 4'b0000;
    expectBusIdle(1);
    dreq = 4'b1111;
    observeCycle(0);
    dreq = 4'b0000;
    expectBusIdle(2);
    finishTest(5, "fixed priority", startErrors);
  endtask

  task automatic rotatingPriorityTest();
    int startErrors;
    startErrors = currentErrors();
    cpuWrite(dmaRegPkg::selCmdStatus, 8'(1 << dmaRegPkg::cmdRotateBit));
    for (int ch = 0; ch < dmaCtrlPkg::numChannels; ch++) begin
      programChannel(ch, 16'($random(seed)), 16'd6,
                     (ch == 2) ? dmaCtrlPkg::xferWrite : dmaCtrlPkg::xferRead);
    end
    // served channel drops to lowest, so grants walk 0 to 3
    dreq = 4'b1111;
    for (int ch = 0; ch < dmaCtrlPkg::numChannels; ch++) begin
      observeCycle(ch);
    end
    dreq = 4'b0000;
    expectBusIdle(2);
    finishTest(6, "rotating priority", startErrors);
  endtask

  initial begin
    rstN = 1'b0;
    csN = 1'b1;
    regWr = 1'b0;
    regRd = 1'b0;
    regSel = '0;
    regWrData = '0;
    dreq = '0;
    seed = 32'h323b;
    // count rising edges seen in reset, then release on a falling edge
    repeat (resetCycles) @(posedge busIf);
    @(negedge busIf);
    rstN = 1'b1;
    resetStateTest();
    registerReadbackTest();
    singleTransferTest();
    terminalCountTest();
    fixedPriorityTest();
    rotatingPriorityTest();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checkCount, currentErrors());
    if (testsFailed == 0 && currentErrors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // run limit, twice the summed test budgets
  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge busIf);
      cycleCount++;
    end
    $display("error: run stopped at the limit of %0d cycles", cycleLimit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: tb.f
hw/dmaRegPkg.sv
hw/dmaCtrlPkg.sv
hw/dmaRegisterFile.sv
hw/dmaPriorityArbiter.sv
hw/dmaTimingControl.sv
hw/dmaTop.sv
tests/dmaClockGen.sv
tests/dmaTiming_checker.sv
tests/dmaTb.sv

// File: Makefile
# Verilator build and run of the DMA controller testbench

VERILATOR ?= verilator
TOP ?= dmaTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal --top-module $(TOP)
RUN_ARGS ?= +verilator+error+limit+1000
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
